/* design/dma_snd_pkg.sv */
// shared definitions for the STE style DMA sound controller
// register word addresses, rate and fetch state encodings, sample types
// referenced by scoped name from every design file
`default_nettype none

package dma_snd_pkg;

	// sample word address, byte address bit 0 is dropped
	localparam int SADDR_W = 23;

	// one memory word of audio, two signed 8 bit samples
	typedef logic [15:0] sample_word_t;

	// cpu register map, word addresses on the 5 bit bus
	typedef enum logic [4:0] {
		REG_CTRL     = 5'h00,
		REG_BASE_HI  = 5'h01,
		REG_BASE_MID = 5'h02,
		REG_BASE_LO  = 5'h03,
		REG_ADR_HI   = 5'h04,
		REG_ADR_MID  = 5'h05,
		REG_ADR_LO   = 5'h06,
		REG_END_HI   = 5'h07,
		REG_END_MID  = 5'h08,
		REG_END_LO   = 5'h09,
		REG_MODE     = 5'h10,
		REG_MW_DATA  = 5'h11,
		REG_MW_MASK  = 5'h12
	} reg_addr_e;

	// sample rate field of the mode register
	typedef enum logic [1:0] {
		RATE_6K25 = 2'd0,
		RATE_12K5 = 2'd1,
		RATE_25K  = 2'd2,
		RATE_50K  = 2'd3
	} rate_e;

	// frame fetch engine
	typedef enum logic {
		FETCH_IDLE = 1'b0,
		FETCH_RUN  = 1'b1
	} fetch_state_e;

endpackage

`default_nettype wire

/* design/dma_snd_if.sv */
// internal bundles of the DMA sound controller
// dma_cfg_if carries frame setup from the register file and fetch status back
// sample_fifo_if connects the fetch engine, the FIFO and the playback engine
`timescale 1ns/1ps
`default_nettype none

interface dma_cfg_if;
	logic [dma_snd_pkg::SADDR_W-1:0] base_addr;
	logic [dma_snd_pkg::SADDR_W-1:0] end_addr;
	logic [dma_snd_pkg::SADDR_W-1:0] cur_addr;
	logic ctrl_en;
	logic ctrl_loop;
	// one cycle pulse, control write with bit 0 set
	logic start;
	logic mode_mono;
	dma_snd_pkg::rate_e rate;
	logic frame_active;

	modport regs (
		output base_addr, end_addr, ctrl_en, ctrl_loop, start, mode_mono, rate,
		input cur_addr, frame_active
	);
	modport fetch (
		input base_addr, end_addr, ctrl_en, ctrl_loop, start,
		output cur_addr, frame_active
	);
	modport play (
		input mode_mono, rate, ctrl_en
	);
endinterface

interface sample_fifo_if #(
	parameter int FIFO_AW = 3
);
	logic push;
	logic pop;
	dma_snd_pkg::sample_word_t wdata;
	// oldest word, valid whenever not empty
	dma_snd_pkg::sample_word_t rdata;
	logic full;
	logic empty;
	// number of stored words
	logic [FIFO_AW-1:0] level;

	modport writer (output push, wdata, input full);
	modport reader (output pop, input rdata, empty);
	modport fifo (input push, pop, wdata, output rdata, full, empty, level);
endinterface

`default_nettype wire

/* design/snd_regs.sv */
// cpu register file of the DMA sound controller
// 16 bit bus with sel/rw/uds/lds, writes on the clock edge, reads combinational
// frame setup goes out over dma_cfg_if, microwire writes go to the serializer
`timescale 1ns/1ps
`default_nettype none

module snd_regs (
	input  logic                   clk,
	input  logic                   xsint,
	input  logic                   sel,
	input  logic                   rw,
	input  logic                   uds,
	input  logic                   lds,
	input  dma_snd_pkg::reg_addr_e addr,
	input  logic [15:0]            din,
	output logic [15:0]            dout,
	dma_cfg_if.regs                cfg,
	output logic                   mw_load,
	output logic                   mw_mask_wr,
	output logic [15:0]            mw_word,
	input  logic [15:0]            mw_mask
);

	logic wr_lds;
	logic wr_mw;
	logic [15:0] mw_data_q;

	// byte registers need the low data strobe
	assign wr_lds = sel && !rw && !lds;
	// microwire is a full 16 bit port, any data strobe will do
	assign wr_mw = sel && !rw && !(uds && lds);

	// --------------------------------------------------
	// write side
	// --------------------------------------------------

	always_ff @(posedge clk or negedge xsint) begin
		if (!xsint) begin
			cfg.ctrl_en   <= 1'b0;
			cfg.ctrl_loop <= 1'b0;
			cfg.start     <= 1'b0;
			cfg.mode_mono <= 1'b0;
			cfg.rate      <= dma_snd_pkg::RATE_6K25;
		end else begin
			// start follows the control write by one cycle
			cfg.start <= wr_lds && (addr == dma_snd_pkg::REG_CTRL) && din[0];
			if (wr_lds && (addr == dma_snd_pkg::REG_CTRL)) begin
				cfg.ctrl_en   <= din[0];
				cfg.ctrl_loop <= din[1];
			end
			// mono flag in bit 7, rate in bits 1:0
			if (wr_lds && (addr == dma_snd_pkg::REG_MODE)) begin
				cfg.mode_mono <= din[7];
				cfg.rate      <= dma_snd_pkg::rate_e'(din[1:0]);
			end
		end
	end

	// frame addresses are split in three byte registers, lo keeps bits 7:1
	always_ff @(posedge clk) begin
		if (wr_lds) begin
			case (addr)
				dma_snd_pkg::REG_BASE_HI:  cfg.base_addr[22:15] <= din[7:0];
				dma_snd_pkg::REG_BASE_MID: cfg.base_addr[14:7]  <= din[7:0];
				dma_snd_pkg::REG_BASE_LO:  cfg.base_addr[6:0]   <= din[7:1];
				dma_snd_pkg::REG_END_HI:   cfg.end_addr[22:15]  <= din[7:0];
				dma_snd_pkg::REG_END_MID:  cfg.end_addr[14:7]   <= din[7:0];
				dma_snd_pkg::REG_END_LO:   cfg.end_addr[6:0]    <= din[7:1];
				default: ;
			endcase
		end
		// copy for read back, the shifter works on its own
		if (mw_load) begin
			mw_data_q <= din;
		end
	end

	// microwire strobes act at the same edge as the bus write
	assign mw_load    = wr_mw && (addr == dma_snd_pkg::REG_MW_DATA);
	assign mw_mask_wr = wr_mw && (addr == dma_snd_pkg::REG_MW_MASK);
	assign mw_word    = din;

	// --------------------------------------------------
	// read mux
	// --------------------------------------------------

	always_comb begin
		dout = 16'h0000;
		if (sel && rw) begin
			case (addr)
				dma_snd_pkg::REG_CTRL:     dout = {14'd0, cfg.ctrl_loop, cfg.frame_active};
				dma_snd_pkg::REG_BASE_HI:  dout = {8'd0, cfg.base_addr[22:15]};
				dma_snd_pkg::REG_BASE_MID: dout = {8'd0, cfg.base_addr[14:7]};
				dma_snd_pkg::REG_BASE_LO:  dout = {8'd0, cfg.base_addr[6:0], 1'b0};
				// current address counter, read only
				dma_snd_pkg::REG_ADR_HI:   dout = {8'd0, cfg.cur_addr[22:15]};
				dma_snd_pkg::REG_ADR_MID:  dout = {8'd0, cfg.cur_addr[14:7]};
				dma_snd_pkg::REG_ADR_LO:   dout = {8'd0, cfg.cur_addr[6:0], 1'b0};
				dma_snd_pkg::REG_END_HI:   dout = {8'd0, cfg.end_addr[22:15]};
				dma_snd_pkg::REG_END_MID:  dout = {8'd0, cfg.end_addr[14:7]};
				dma_snd_pkg::REG_END_LO:   dout = {8'd0, cfg.end_addr[6:0], 1'b0};
				dma_snd_pkg::REG_MODE:     dout = {8'd0, cfg.mode_mono, 5'd0, cfg.rate};
				dma_snd_pkg::REG_MW_DATA:  dout = mw_data_q;
				// live mask, it rotates during a transfer
				dma_snd_pkg::REG_MW_MASK:  dout = mw_mask;
				default:                   dout = 16'h0000;
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/mw_serializer.sv */
// microwire serializer for the audio mixer port
// a load starts a 16 bit transfer, one bit every 8 clocks under a rotating mask
// mw_done pulses once the 7 bit counter has run out
`timescale 1ns/1ps
`default_nettype none

module mw_serializer (
	input  logic        clk,
	input  logic        xsint,
	input  logic        load,
	input  logic [15:0] load_data,
	input  logic        mask_wr,
	input  logic [15:0] mask_data,
	output logic [15:0] mask,
	output logic        mw_clk,
	output logic        mw_data,
	output logic        mw_done
);

	logic [15:0] shift_q;
	logic [6:0] cnt;
	logic step;

	// next bit every 8 clocks while the counter runs
	assign step = (cnt != 7'd0) && (cnt[2:0] == 3'd0);

	always_ff @(posedge clk or negedge xsint) begin
		if (!xsint) begin
			mask    <= 16'h0000;
			shift_q <= 16'h0000;
			cnt     <= 7'd0;
			mw_clk  <= 1'b0;
			mw_data <= 1'b0;
			mw_done <= 1'b0;
		end else begin
			mw_done <= (cnt == 7'd1);
			if (cnt != 7'd0) begin
				cnt <= cnt - 7'd1;
			end
			// load wins over the counter, bit 15 leaves right away
			if (load) begin
				shift_q <= {load_data[14:0], 1'b0};
				mw_data <= load_data[15];
				cnt     <= 7'd127;
			end else if (step) begin
				shift_q <= {shift_q[14:0], 1'b0};
				mw_data <= shift_q[15];
			end
			// mw_clk shows the mask bit leaving with the data bit
			if (mask_wr) begin
				mask <= mask_data;
			end else if (load || step) begin
				mask   <= {mask[14:0], mask[15]};
				mw_clk <= mask[15];
			end
		end
	end

endmodule

`default_nettype wire

/* design/frame_fetch.sv */
// frame fetch engine, reads sample words from the 64 bit memory port
// only in bus slots inside hsync, pushes them into the sample FIFO
// also makes frame_active and its slow 8 stage delayed copy
`timescale 1ns/1ps
`default_nettype none

module frame_fetch (
	input  logic                            clk,
	input  logic                            xsint,
	input  logic                            hsync,
	input  logic                            bus_slot,
	output logic                            mem_read,
	output logic [dma_snd_pkg::SADDR_W-1:0] mem_addr,
	input  logic [63:0]                     mem_data,
	dma_cfg_if.fetch                        cfg,
	sample_fifo_if.writer                   fifo,
	output logic                            frame_active_d
);

	dma_snd_pkg::fetch_state_e state;
	logic [dma_snd_pkg::SADDR_W-1:0] end_latched;
	logic at_end;
	logic slot;
	logic [1:0] pre_cnt;
	logic [7:0] delay_q;

	// end points to the first word after the frame
	assign at_end = (cfg.cur_addr == end_latched);
	// usable slot, FIFO full is the back-pressure
	assign slot = (state == dma_snd_pkg::FETCH_RUN) && hsync && bus_slot && !fifo.full;

	assign mem_read = slot && !at_end;
	assign mem_addr = cfg.cur_addr;

	// address bits 1:0 pick the 16 bit lane, lane 0 is lowest
	assign fifo.push  = mem_read;
	assign fifo.wdata = mem_data[cfg.cur_addr[1:0]*16 +: 16];

	// --------------------------------------------------
	// fetch fsm and address counter
	// --------------------------------------------------

	always_ff @(posedge clk or negedge xsint) begin
		if (!xsint) begin
			state            <= dma_snd_pkg::FETCH_IDLE;
			cfg.cur_addr     <= '0;
			end_latched      <= '0;
			cfg.frame_active <= 1'b0;
		end else begin
			// loop mode keeps the flag up across the wrap
			cfg.frame_active <= (state == dma_snd_pkg::FETCH_RUN) &&
				(!at_end || cfg.ctrl_loop);
			if (!cfg.ctrl_en) begin
				state <= dma_snd_pkg::FETCH_IDLE;
			end else begin
				case (state)
					dma_snd_pkg::FETCH_IDLE: begin
						if (cfg.start) begin
							state        <= dma_snd_pkg::FETCH_RUN;
							cfg.cur_addr <= cfg.base_addr;
							end_latched  <= cfg.end_addr;
						end
					end
					default: begin
						if (slot) begin
							if (!at_end) begin
								cfg.cur_addr <= cfg.cur_addr + 1'b1;
							end else if (cfg.ctrl_loop) begin
								// restart the frame with fresh addresses
								cfg.cur_addr <= cfg.base_addr;
								end_latched  <= cfg.end_addr;
							end else begin
								state <= dma_snd_pkg::FETCH_IDLE;
							end
						end
					end
				endcase
			end
		end
	end

	// --------------------------------------------------
	// frame_active delay, 8 stages at clk/4
	// --------------------------------------------------

	always_ff @(posedge clk or negedge xsint) begin
		if (!xsint) begin
			pre_cnt <= 2'd0;
			delay_q <= 8'h00;
		end else begin
			pre_cnt <= pre_cnt + 2'd1;
			if (pre_cnt == 2'd3) begin
				delay_q <= {delay_q[6:0], cfg.frame_active};
			end
		end
	end

	assign frame_active_d = delay_q[7];

endmodule

`default_nettype wire

/* design/sample_fifo.sv */
// circular buffer of sample words between fetch and playback
// holds at most 2^FIFO_AW - 1 words, one slot stays free
// rdata always shows the oldest word, bad push or pop is dropped
`timescale 1ns/1ps
`default_nettype none

module sample_fifo #(
	parameter int FIFO_AW = 3
) (
	input  logic       clk,
	input  logic       xsint,
	sample_fifo_if.fifo f
);

	dma_snd_pkg::sample_word_t mem [2**FIFO_AW];
	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;

	// pointer distance wraps naturally
	assign f.level = wr_ptr - rd_ptr;
	assign f.empty = (f.level == '0);
	assign f.full  = (f.level == '1);
	assign f.rdata = mem[rd_ptr];

	always_ff @(posedge clk or negedge xsint) begin
		if (!xsint) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (f.push && !f.full) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (f.pop && !f.empty) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (f.push && !f.full) begin
			mem[wr_ptr] <= f.wdata;
		end
	end

endmodule

`default_nettype wire

/* design/snd_playback.sv */
// playback engine, empties the sample FIFO at the programmed rate
// fractional divider of clk gives the 50 kHz base, then divide by 1, 2, 4 or 8
// stereo takes high byte left and low byte right, mono alternates bytes
`timescale 1ns/1ps
`default_nettype none

module snd_playback #(
	parameter int unsigned CLK_HZ  = 8_000_000,
	parameter int unsigned BASE_HZ = 50_066
) (
	input  logic         clk,
	input  logic         xsint,
	dma_cfg_if.play      cfg,
	sample_fifo_if.reader fifo,
	output logic [7:0]   audio_l,
	output logic [7:0]   audio_r,
	output logic         audio_strobe
);

	localparam logic [31:0] HALF = 32'(CLK_HZ / 2);
	localparam logic [31:0] STEP = 32'(BASE_HZ);

	logic [31:0] acc;
	logic wave;
	logic wrap;
	logic base_tick;
	logic [2:0] tick_cnt;
	logic [2:0] div_mask;
	logic sample_tick;
	logic play;
	logic byte_sel;
	logic [7:0] mono_byte;

	// --------------------------------------------------
	// rate generation
	// --------------------------------------------------

	assign wrap = (acc >= HALF);
	// base tick is the wrap that raises the wave
	assign base_tick = wrap && !wave;

	always_comb begin
		case (cfg.rate)
			dma_snd_pkg::RATE_50K:  div_mask = 3'b000;
			dma_snd_pkg::RATE_25K:  div_mask = 3'b001;
			dma_snd_pkg::RATE_12K5: div_mask = 3'b011;
			default:                div_mask = 3'b111;
		endcase
	end

	assign sample_tick = base_tick && ((tick_cnt & div_mask) == div_mask);
	assign play = sample_tick && !fifo.empty;

	// --------------------------------------------------
	// output stage
	// --------------------------------------------------

	// mono pops after the low byte, stereo on every sample
	assign fifo.pop  = play && (!cfg.mode_mono || byte_sel);
	assign mono_byte = byte_sel ? fifo.rdata[7:0] : fifo.rdata[15:8];

	always_ff @(posedge clk or negedge xsint) begin
		if (!xsint) begin
			acc          <= 32'd0;
			wave         <= 1'b0;
			tick_cnt     <= 3'd0;
			byte_sel     <= 1'b0;
			audio_strobe <= 1'b0;
		end else begin
			acc <= wrap ? (acc - HALF + STEP) : (acc + STEP);
			if (wrap) begin
				wave <= !wave;
			end
			if (base_tick) begin
				tick_cnt <= tick_cnt + 3'd1;
			end
			audio_strobe <= play;
			// back to the high byte once playback is stopped and drained
			if (fifo.empty && !cfg.ctrl_en) begin
				byte_sel <= 1'b0;
			end else if (play && cfg.mode_mono) begin
				byte_sel <= !byte_sel;
			end
		end
	end

	// signed samples to offset binary, outputs hold while empty
	always_ff @(posedge clk) begin
		if (play) begin
			if (cfg.mode_mono) begin
				audio_l <= mono_byte + 8'd128;
				audio_r <= mono_byte + 8'd128;
			end else begin
				audio_l <= fifo.rdata[15:8] + 8'd128;
				audio_r <= fifo.rdata[7:0] + 8'd128;
			end
		end
	end

endmodule

`default_nettype wire

/* design/ste_dma_snd.sv */
// top level of the STE style DMA sound controller
// cpu register bus, 64 bit memory read port, audio bytes with strobe
// frame status and microwire lines as plain ports
`timescale 1ns/1ps
`default_nettype none

module ste_dma_snd #(
	parameter int          FIFO_AW = 3,
	parameter int unsigned CLK_HZ  = 8_000_000,
	parameter int unsigned BASE_HZ = 50_066
) (
	input  logic        clk,
	input  logic        xsint,
	// cpu bus
	input  logic        sel,
	input  logic        rw,
	input  logic        uds,
	input  logic        lds,
	input  logic [4:0]  addr,
	input  logic [15:0] din,
	output logic [15:0] dout,
	// memory port, used inside hsync only
	input  logic        hsync,
	input  logic        bus_slot,
	output logic        mem_read,
	output logic [22:0] mem_addr,
	input  logic [63:0] mem_data,
	// audio out
	output logic [7:0]  audio_l,
	output logic [7:0]  audio_r,
	output logic        audio_strobe,
	output logic        frame_active,
	output logic        frame_active_d,
	// microwire
	output logic        mw_clk,
	output logic        mw_data,
	output logic        mw_done
);

	logic mw_load;
	logic mw_mask_wr;
	logic [15:0] mw_word;
	logic [15:0] mw_mask;

	dma_cfg_if cfg_if ();
	sample_fifo_if #(.FIFO_AW(FIFO_AW)) fifo_if ();

	assign frame_active = cfg_if.frame_active;

	snd_regs snd_regs_inst (
		.clk        (clk),
		.xsint      (xsint),
		.sel        (sel),
		.rw         (rw),
		.uds        (uds),
		.lds        (lds),
		.addr       (dma_snd_pkg::reg_addr_e'(addr)),
		.din        (din),
		.dout       (dout),
		.cfg        (cfg_if.regs),
		.mw_load    (mw_load),
		.mw_mask_wr (mw_mask_wr),
		.mw_word    (mw_word),
		.mw_mask    (mw_mask)
	);

	mw_serializer mw_serializer_inst (
		.clk       (clk),
		.xsint     (xsint),
		.load      (mw_load),
		.load_data (mw_word),
		.mask_wr   (mw_mask_wr),
		.mask_data (mw_word),
		.mask      (mw_mask),
		.mw_clk    (mw_clk),
		.mw_data   (mw_data),
		.mw_done   (mw_done)
	);

	frame_fetch frame_fetch_inst (
		.clk            (clk),
		.xsint          (xsint),
		.hsync          (hsync),
		.bus_slot       (bus_slot),
		.mem_read       (mem_read),
		.mem_addr       (mem_addr),
		.mem_data       (mem_data),
		.cfg            (cfg_if.fetch),
		.fifo           (fifo_if.writer),
		.frame_active_d (frame_active_d)
	);

	sample_fifo #(.FIFO_AW(FIFO_AW)) sample_fifo_inst (
		.clk   (clk),
		.xsint (xsint),
		.f     (fifo_if.fifo)
	);

	snd_playback #(
		.CLK_HZ  (CLK_HZ),
		.BASE_HZ (BASE_HZ)
	) snd_playback_inst (
		.clk          (clk),
		.xsint        (xsint),
		.cfg          (cfg_if.play),
		.fifo         (fifo_if.reader),
		.audio_l      (audio_l),
		.audio_r      (audio_r),
		.audio_strobe (audio_strobe)
	);

endmodule

`default_nettype wire

/* tb/tb_ste_dma_snd.sv */
// testbench for the STE style DMA sound controller
// random hsync and bus slots with a fixed seed, a memory model on the 64 bit port
// and a reference queue of fetched words that predicts every audio strobe
// run from the project root with verilog.f, top module tb_ste_dma_snd
`timescale 1ns/1ps
`default_nettype none

module tb_ste_dma_snd;

	logic clk;
	logic xsint;
	logic sel;
	logic rw;
	logic uds;
	logic lds;
	logic [4:0] addr;
	logic [15:0] din;
	logic [15:0] dout;
	logic hsync;
	logic bus_slot;
	logic mem_read;
	logic [22:0] mem_addr;
	logic [63:0] mem_data;
	logic [7:0] audio_l;
	logic [7:0] audio_r;
	logic audio_strobe;
	logic frame_active;
	logic frame_active_d;
	logic mw_clk;
	logic mw_data;
	logic mw_done;

	int seed = 38075;
	int errors = 0;
	int tests = 0;
	int wd_limit = 1000000;
	int len_tab [1:5];
	// reference model state
	logic [15:0] exp_q [$];
	int fa_times [$];
	logic [22:0] base_w;
	logic [22:0] end_w;
	logic [22:0] next_addr;
	logic loop_on;
	logic mono_on;
	logic phase;
	int div;
	int reads;
	int cyc;
	int last_strobe;
	logic last_valid;
	logic starved;
	logic loop_check;
	logic hsync_en;
	logic fa_prev;
	logic fad_prev;
	logic [15:0] w;
	logic [7:0] b;

	ste_dma_snd ste_dma_snd_inst (
		.clk(clk), .xsint(xsint), .sel(sel), .rw(rw), .uds(uds), .lds(lds),
		.addr(addr), .din(din), .dout(dout), .hsync(hsync), .bus_slot(bus_slot),
		.mem_read(mem_read), .mem_addr(mem_addr), .mem_data(mem_data),
		.audio_l(audio_l), .audio_r(audio_r), .audio_strobe(audio_strobe),
		.frame_active(frame_active), .frame_active_d(frame_active_d),
		.mw_clk(mw_clk), .mw_data(mw_data), .mw_done(mw_done)
	);

	always #5 clk = ~clk;

	// memory content, one 16 bit value per word address
	function automatic logic [15:0] sample_at(input logic [22:0] a);
		return a[15:0] ^ {a[22:16], 9'h000} ^ 16'h5a3c;
	endfunction

	// 64 bit memory word holds four sample words, lane 0 lowest
	always_comb begin
		mem_data = {sample_at({mem_addr[22:2], 2'd3}), sample_at({mem_addr[22:2], 2'd2}),
			sample_at({mem_addr[22:2], 2'd1}), sample_at({mem_addr[22:2], 2'd0})};
	end

	// random hsync duty, bus slots only inside hsync
	always @(posedge clk) begin
		if (hsync_en && (($random(seed) & 3) != 0)) begin
			hsync    <= 1'b1;
			bus_slot <= ($random(seed) & 1);
		end else begin
			hsync    <= 1'b0;
			bus_slot <= 1'b0;
		end
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	// --------------------------------------------------
	// monitor, samples at the falling edge
	// --------------------------------------------------

	always @(negedge clk) begin
		if (xsint) begin
			if (exp_q.size() == 0) begin
				starved = 1'b1;
			end
			if (mem_read) begin
				assert (mem_addr == next_addr) else begin
					errors++;
					$display("[FAIL] %0t: fetch address %h, expected %h", $time, mem_addr, next_addr);
				end
				assert (loop_on || mem_addr != end_w) else begin
					errors++;
					$display("[FAIL] %0t: fetch past frame end at %h", $time, mem_addr);
				end
				exp_q.push_back(sample_at(mem_addr));
				reads++;
				next_addr = next_addr + 1'b1;
				if (loop_on && next_addr == end_w) begin
					next_addr = base_w;
				end
			end
			if (frame_active != fa_prev) begin
				fa_times.push_back(cyc);
				fa_prev = frame_active;
			end
			if (frame_active_d != fad_prev) begin
				fad_prev = frame_active_d;
				assert (fa_times.size() > 0 && cyc - fa_times[0] >= 28 && cyc - fa_times[0] <= 33)
				else begin
					errors++;
					$display("[FAIL] %0t: frame_active_d edge without matching delay", $time);
				end
				if (fa_times.size() > 0) begin
					void'(fa_times.pop_front());
				end
			end
			if (loop_check) begin
				assert (frame_active) else begin
					errors++;
					$display("[FAIL] %0t: frame_active dropped in loop mode", $time);
				end
			end
			if (audio_strobe) begin
				assert (exp_q.size() > 0) else begin
					errors++;
					$display("[FAIL] %0t: audio strobe with no fetched word", $time);
				end
				if (exp_q.size() > 0) begin
					w = exp_q[0];
					if (mono_on) begin
						b = phase ? w[7:0] : w[15:8];
						assert (audio_l == 8'(b + 8'd128) && audio_r == audio_l) else begin
							errors++;
							$display("[FAIL] %0t: mono out %h/%h, expected %h", $time,
								audio_l, audio_r, 8'(b + 8'd128));
						end
						if (phase) begin
							void'(exp_q.pop_front());
						end
						phase = !phase;
					end else begin
						assert (audio_l == 8'(w[15:8] + 8'd128) && audio_r == 8'(w[7:0] + 8'd128))
						else begin
							errors++;
							$display("[FAIL] %0t: stereo out %h/%h, word %h", $time,
								audio_l, audio_r, w);
						end
						void'(exp_q.pop_front());
					end
				end
				// base period of 159 or 160 clocks times the rate divisor
				if (last_valid && !starved) begin
					assert (cyc - last_strobe >= 159 * div && cyc - last_strobe <= 160 * div)
					else begin
						errors++;
						$display("[FAIL] %0t: strobe spacing %0d, divisor %0d", $time,
							cyc - last_strobe, div);
					end
				end
				last_strobe = cyc;
				last_valid = 1'b1;
				starved = (exp_q.size() == 0);
			end
		end
	end

	// --------------------------------------------------
	// bus tasks
	// --------------------------------------------------

	task automatic bus_write(input logic [4:0] a, input logic [15:0] d);
		@(posedge clk);
		sel <= 1'b1;
		rw <= 1'b0;
		uds <= 1'b0;
		lds <= 1'b0;
		addr <= a;
		din <= d;
		@(posedge clk);
		sel <= 1'b0;
		rw <= 1'b1;
		uds <= 1'b1;
		lds <= 1'b1;
	endtask

	task automatic read_check(input logic [4:0] a, input logic [15:0] exp, input string what);
		@(posedge clk);
		sel <= 1'b1;
		rw <= 1'b1;
		addr <= a;
		@(negedge clk);
		assert (dout == exp) else begin
			errors++;
			$display("[FAIL] %0t: read %s gave %h, expected %h", $time, what, dout, exp);
		end
		@(posedge clk);
		sel <= 1'b0;
	endtask

	// program a random frame and start it
	// unused bits of the byte registers carry random junk
	task automatic start_frame(input int len, input logic mono, input logic [1:0] rate,
		input logic loop);
		logic [15:0] pad;
		base_w = $random(seed) & 23'h3fffff;
		end_w = base_w + len;
		pad = $random(seed);
		bus_write(5'h01, {pad[15:8], base_w[22:15]});
		bus_write(5'h02, {pad[7:0], base_w[14:7]});
		bus_write(5'h03, {pad[15:8], base_w[6:0], pad[0]});
		bus_write(5'h07, {pad[7:0], end_w[22:15]});
		bus_write(5'h08, {pad[15:8], end_w[14:7]});
		bus_write(5'h09, {pad[7:0], end_w[6:0], pad[1]});
		bus_write(5'h10, {pad[15:8], mono, pad[6:2], rate});
		next_addr = base_w;
		loop_on = loop;
		mono_on = mono;
		div = 1 << (3 - rate);
		reads = 0;
		last_valid = 1'b0;
		bus_write(5'h00, {14'd0, loop, 1'b1});
	endtask

	// stop, let playback empty the FIFO and the delay line settle
	task automatic drain();
		bus_write(5'h00, 16'h0000);
		while (exp_q.size() != 0) @(negedge clk);
		repeat (60) @(posedge clk);
		// every frame_active edge must have reached frame_active_d by now
		assert (fa_times.size() == 0) else begin
			errors++;
			$display("[FAIL] %0t: frame_active_d missed %0d frame_active edges", $time,
				fa_times.size());
		end
	endtask

	task automatic report(input string name, input int err_before);
		tests++;
		$display("test %0d %s: %0d errors", tests, name, errors - err_before);
	endtask

	task automatic one_shot(input int len, input logic mono, input logic [1:0] rate,
		input string name);
		int e0;
		int r0;
		e0 = errors;
		hsync_en = 1'b1;
		start_frame(len, mono, rate, 1'b0);
		wait (reads == len);
		@(negedge clk);
		while (frame_active) @(negedge clk);
		r0 = reads;
		repeat (100) @(posedge clk);
		assert (reads == r0) else begin
			errors++;
			$display("[FAIL] %0t: fetch after frame end", $time);
		end
		drain();
		report(name, e0);
	endtask

	// --------------------------------------------------
	// test sequence
	// --------------------------------------------------

	initial begin
		int e0;
		int r0;
		logic [15:0] mw_d;
		logic [15:0] mw_m;
		clk = 0;
		xsint = 0;
		sel = 0;
		rw = 1;
		uds = 1;
		lds = 1;
		addr = 0;
		din = 0;
		hsync = 0;
		bus_slot = 0;
		cyc = 0;
		phase = 0;
		starved = 1;
		last_valid = 0;
		loop_check = 0;
		hsync_en = 0;
		fa_prev = 0;
		fad_prev = 0;
		loop_on = 0;
		mono_on = 0;
		div = 1;
		reads = 0;
		base_w = 0;
		end_w = 0;
		next_addr = 0;
		for (int i = 1; i <= 5; i++) begin
			len_tab[i] = 8 + ($unsigned($random(seed)) % 16);
		end
		wd_limit = 60000;
		for (int i = 1; i <= 5; i++) begin
			wd_limit += len_tab[i] * 3 * 8 * 160 * 2;
		end
		repeat (5) @(posedge clk);
		xsint <= 1'b1;

		// register access, no fetch while hsync stays low
		e0 = errors;
		start_frame(len_tab[1], $random(seed) & 1, $random(seed) & 3, 1'b0);
		read_check(5'h01, {8'd0, base_w[22:15]}, "base hi");
		read_check(5'h02, {8'd0, base_w[14:7]}, "base mid");
		read_check(5'h03, {8'd0, base_w[6:0], 1'b0}, "base lo");
		read_check(5'h07, {8'd0, end_w[22:15]}, "end hi");
		read_check(5'h08, {8'd0, end_w[14:7]}, "end mid");
		read_check(5'h09, {8'd0, end_w[6:0], 1'b0}, "end lo");
		read_check(5'h10, {8'd0, mono_on, 5'd0, 2'(3 - $clog2(div))}, "mode");
		read_check(5'h04, {8'd0, base_w[22:15]}, "addr hi");
		read_check(5'h05, {8'd0, base_w[14:7]}, "addr mid");
		read_check(5'h06, {8'd0, base_w[6:0], 1'b0}, "addr lo");
		mw_m = $random(seed);
		mw_d = $random(seed);
		bus_write(5'h12, mw_m);
		read_check(5'h12, mw_m, "mw mask");
		bus_write(5'h11, mw_d);
		read_check(5'h11, mw_d, "mw data");
		repeat (50) @(posedge clk);
		drain();
		report("register access", e0);

		one_shot(len_tab[2], 1'b0, $random(seed) & 3, "one-shot fetch");
		one_shot(len_tab[3], 1'b0, dma_snd_pkg::RATE_50K, "stereo playback");
		one_shot(len_tab[4], 1'b1, $random(seed) & 3, "mono playback");

		// loop mode, two full wraps then disable
		e0 = errors;
		start_frame(len_tab[5], 1'b0, dma_snd_pkg::RATE_50K, 1'b1);
		wait (reads >= 1);
		loop_check = 1'b1;
		wait (reads >= 2 * len_tab[5] + 2);
		loop_check = 1'b0;
		bus_write(5'h00, 16'h0000);
		repeat (3) @(posedge clk);
		r0 = reads;
		repeat (100) @(posedge clk);
		assert (reads == r0) else begin
			errors++;
			$display("[FAIL] %0t: fetch continued after ctrl_en cleared", $time);
		end
		loop_on = 1'b0;
		drain();
		report("loop mode", e0);

		// microwire, bit k shows 1 + 8k cycles after the write
		e0 = errors;
		mw_m = $random(seed);
		mw_d = $random(seed);
		bus_write(5'h12, mw_m);
		bus_write(5'h11, mw_d);
		for (int n = 1; n <= 140; n++) begin
			@(negedge clk);
			if ((n - 1) % 8 == 0 && n <= 121) begin
				assert (mw_data == mw_d[15 - (n - 1) / 8] && mw_clk == mw_m[15 - (n - 1) / 8])
				else begin
					errors++;
					$display("[FAIL] %0t: microwire bit %0d wrong", $time, (n - 1) / 8);
				end
			end
			assert (mw_done == (n == 128)) else begin
				errors++;
				$display("[FAIL] %0t: mw_done is %b at cycle %0d", $time, mw_done, n - 1);
			end
		end
		report("microwire", e0);

		$display("tests run: %0d, errors: %0d", tests, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	// watchdog, limit from the frame lengths at the slowest rate
	initial begin
		#1;
		#(wd_limit * 10);
		$display("watchdog expired, the run did not finish in time");
		$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
design/dma_snd_pkg.sv
design/dma_snd_if.sv
design/snd_regs.sv
design/mw_serializer.sv
design/frame_fetch.sv
design/sample_fifo.sv
design/snd_playback.sv
design/ste_dma_snd.sv
tb/tb_ste_dma_snd.sv

/* Bender.yml */
package:
  name: ste_dma_snd

sources:
  - design/dma_snd_pkg.sv
  - design/dma_snd_if.sv
  - design/snd_regs.sv
  - design/mw_serializer.sv
  - design/frame_fetch.sv
  - design/sample_fifo.sv
  - design/snd_playback.sv
  - design/ste_dma_snd.sv
  - target: test
    files:
      - tb/tb_ste_dma_snd.sv
